/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM14_W    = 14;
	localparam int IMM24_W    = 24;

	// Instruction field positions, both immediates start at bit 0
	localparam int OPCODE_HI = 30;
	localparam int OPCODE_LO = 25;
	localparam int RT_HI     = 24;
	localparam int RT_LO     = 20;
	localparam int RA_HI     = 19;
	localparam int RA_LO     = 15;
	localparam int RB_HI     = 14;
	localparam int RB_LO     = 10;
	localparam int SUB_HI    = 4;
	localparam int SUB_LO    = 0;

	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_LWI  = 6'h02,
		OP_SWI  = 6'h0a,
		OP_ALU  = 6'h20,
		OP_MOVI = 6'h22,
		OP_ADDI = 6'h28
	} opcode_e;

	typedef enum logic [4:0] {
		SUB_ADD = 5'h00,
		SUB_SUB = 5'h01,
		SUB_AND = 5'h02,
		SUB_XOR = 5'h03,
		SUB_OR  = 5'h04
	} sub_op_e;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM} wb_sel_e;

	// NOP is opcode zero with every other field zero
	localparam logic [DATA_W-1:0] NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

/* rtl/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if #(
	parameter int ADDR_W = 16
);
	import cpu_pkg::*;

	logic              req;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              gnt;

	modport manager (
		output req, we, addr, wdata,
		input  rdata, gnt
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output rdata, gnt
	);

endinterface

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int ADDR_W = 16
) (
	input  wire                         clock,
	input  wire                         rst_n,
	mem_bus_if.manager                  fetch_bus,
	output logic [cpu_pkg::DATA_W-1:0] instruction
);
	import cpu_pkg::*;

	logic [ADDR_W-1:0] pc;
	logic              fetch_en;

	// The first request goes out one edge after reset is released
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			if (fetch_bus.gnt)
				pc <= pc + ADDR_W'(4);
		end
	end

	assign fetch_bus.req   = fetch_en;
	assign fetch_bus.we    = 1'b0;
	assign fetch_bus.addr  = pc;
	assign fetch_bus.wdata = '0;

	// A lost slot becomes a bubble and the same PC is asked for again
	assign instruction = fetch_bus.gnt ? fetch_bus.rdata : NOP_WORD;

endmodule

`default_nettype wire

/* rtl/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  wire  [cpu_pkg::DATA_W-1:0]     instruction,
	output cpu_pkg::opcode_e               opcode,
	output cpu_pkg::alu_op_e               alu_op,
	output logic [cpu_pkg::REG_ADDR_W-1:0] rt,
	output logic [cpu_pkg::REG_ADDR_W-1:0] ra,
	output logic [cpu_pkg::REG_ADDR_W-1:0] rb,
	output logic [cpu_pkg::DATA_W-1:0]     imm_extend,
	output logic                           use_imm,
	output cpu_pkg::wb_sel_e               wb_sel,
	output logic                           do_dm_read,
	output logic                           do_dm_write,
	output logic                           do_reg_write
);
	import cpu_pkg::*;

	logic [5:0]         op_raw;
	logic [4:0]         sub_raw;
	logic [IMM14_W-1:0] imm14;
	logic [IMM24_W-1:0] imm24;

	assign op_raw  = instruction[OPCODE_HI:OPCODE_LO];
	assign sub_raw = instruction[SUB_HI:SUB_LO];
	assign imm14   = instruction[IMM14_W-1:0];
	assign imm24   = instruction[IMM24_W-1:0];

	assign rt = instruction[RT_HI:RT_LO];
	assign ra = instruction[RA_HI:RA_LO];
	assign rb = instruction[RB_HI:RB_LO];

	always_comb begin
		opcode       = OP_NOP;
		alu_op       = ALU_ADD;
		use_imm      = 1'b0;
		wb_sel       = WB_ALU;
		do_dm_read   = 1'b0;
		do_dm_write  = 1'b0;
		do_reg_write = 1'b0;
		imm_extend   = {{(DATA_W-IMM14_W){imm14[IMM14_W-1]}}, imm14};
		case (op_raw)
			OP_ALU: begin
				opcode       = OP_ALU;
				do_reg_write = 1'b1;
				case (sub_raw)
					SUB_ADD: alu_op = ALU_ADD;
					SUB_SUB: alu_op = ALU_SUB;
					SUB_AND: alu_op = ALU_AND;
					SUB_OR:  alu_op = ALU_OR;
					SUB_XOR: alu_op = ALU_XOR;
					// Unknown sub-opcodes do nothing
					default: do_reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				opcode       = OP_ADDI;
				use_imm      = 1'b1;
				do_reg_write = 1'b1;
			end
			OP_MOVI: begin
				opcode       = OP_MOVI;
				wb_sel       = WB_IMM;
				imm_extend   = {{(DATA_W-IMM24_W){imm24[IMM24_W-1]}}, imm24};
				do_reg_write = 1'b1;
			end
			OP_LWI: begin
				opcode       = OP_LWI;
				use_imm      = 1'b1;
				wb_sel       = WB_MEM;
				do_dm_read   = 1'b1;
				do_reg_write = 1'b1;
			end
			OP_SWI: begin
				opcode      = OP_SWI;
				use_imm     = 1'b1;
				do_dm_write = 1'b1;
			end
			default: opcode = OP_NOP;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire                            clock,
	input  wire                            rst_n,
	input  wire  [cpu_pkg::REG_ADDR_W-1:0] ra_addr,
	input  wire  [cpu_pkg::REG_ADDR_W-1:0] rb_addr,
	input  wire                            write_en,
	input  wire  [cpu_pkg::REG_ADDR_W-1:0] write_addr,
	input  wire  [cpu_pkg::DATA_W-1:0]     write_data,
	output logic [cpu_pkg::DATA_W-1:0]     ra_data,
	output logic [cpu_pkg::DATA_W-1:0]     rb_data
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [2**REG_ADDR_W];

	// A register being written this cycle reads as its new value
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (write_en && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
	end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_e           alu_op,
	input  wire  [cpu_pkg::DATA_W-1:0] src1,
	input  wire  [cpu_pkg::DATA_W-1:0] src2,
	output logic [cpu_pkg::DATA_W-1:0] result,
	output logic                       overflow
);
	import cpu_pkg::*;

	localparam int MSB = DATA_W - 1;

	always_comb begin
		overflow = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result   = src1 + src2;
				overflow = (src1[MSB] == src2[MSB]) && (result[MSB] != src1[MSB]);
			end
			ALU_SUB: begin
				result   = src1 - src2;
				overflow = (src1[MSB] != src2[MSB]) && (result[MSB] != src1[MSB]);
			end
			ALU_AND: result = src1 & src2;
			ALU_OR:  result = src1 | src2;
			ALU_XOR: result = src1 ^ src2;
			default: result = src1 + src2;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/regwalls.sv */
`timescale 1ns/1ps
`default_nettype none

module regwalls (
	input  wire                            clock,
	input  wire                            rst_n,

	input  wire  [cpu_pkg::DATA_W-1:0]     if_instruction,
	output logic [cpu_pkg::DATA_W-1:0]     id_instruction,

	input  wire  [cpu_pkg::DATA_W-1:0]     id_ra_data,
	input  wire  [cpu_pkg::DATA_W-1:0]     id_src2,
	input  cpu_pkg::alu_op_e               id_alu_op,
	output logic [cpu_pkg::DATA_W-1:0]     ex_ra_data,
	output logic [cpu_pkg::DATA_W-1:0]     ex_src2,
	output cpu_pkg::alu_op_e               ex_alu_op,

	input  cpu_pkg::wb_sel_e               id_wb_sel,
	input  wire  [cpu_pkg::DATA_W-1:0]     id_imm_extend,
	input  wire  [cpu_pkg::DATA_W-1:0]     id_store_data,
	output cpu_pkg::wb_sel_e               ma_wb_sel,
	output logic [cpu_pkg::DATA_W-1:0]     ma_imm_extend,
	output logic [cpu_pkg::DATA_W-1:0]     ma_store_data,

	input  wire  [cpu_pkg::REG_ADDR_W-1:0] id_write_addr,
	input  wire                            id_do_dm_read,
	input  wire                            id_do_dm_write,
	input  wire                            id_do_reg_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wb_write_addr,
	output logic                           ma_do_dm_read,
	output logic                           ma_do_dm_write,
	output logic                           wb_do_reg_write,

	input  wire  [cpu_pkg::DATA_W-1:0]     ex_alu_result,
	input  wire                            ex_overflow,
	output logic [cpu_pkg::DATA_W-1:0]     ma_alu_result,
	output logic                           ma_overflow,

	input  wire  [cpu_pkg::DATA_W-1:0]     ma_write_data,
	output logic [cpu_pkg::DATA_W-1:0]     wb_write_data
);
	import cpu_pkg::*;

	// Values that wait in a middle wall before reaching their stage
	logic [REG_ADDR_W-1:0] ex_write_addr;
	logic [REG_ADDR_W-1:0] ma_write_addr;
	logic                  ex_do_dm_read;
	logic                  ex_do_dm_write;
	logic                  ex_do_reg_write;
	logic                  ma_do_reg_write;
	wb_sel_e               ex_wb_sel;
	logic [DATA_W-1:0]     ex_imm_extend;
	logic [DATA_W-1:0]     ex_store_data;

	always_ff @(negedge clock or negedge rst_n) begin
		if (!rst_n) begin
			id_instruction  <= NOP_WORD;
			ex_do_dm_read   <= 1'b0;
			ex_do_dm_write  <= 1'b0;
			ex_do_reg_write <= 1'b0;
			ma_do_dm_read   <= 1'b0;
			ma_do_dm_write  <= 1'b0;
			ma_do_reg_write <= 1'b0;
			wb_do_reg_write <= 1'b0;
			ma_overflow     <= 1'b0;
		end else begin
			id_instruction  <= if_instruction;
			ex_do_dm_read   <= id_do_dm_read;
			ex_do_dm_write  <= id_do_dm_write;
			ex_do_reg_write <= id_do_reg_write;
			ma_do_dm_read   <= ex_do_dm_read;
			ma_do_dm_write  <= ex_do_dm_write;
			ma_do_reg_write <= ex_do_reg_write;
			wb_do_reg_write <= ma_do_reg_write;
			ma_overflow     <= ex_overflow;
		end
	end

	always_ff @(negedge clock) begin
		ex_ra_data    <= id_ra_data;
		ex_src2       <= id_src2;
		ex_alu_op     <= id_alu_op;
		ex_wb_sel     <= id_wb_sel;
		ma_wb_sel     <= ex_wb_sel;
		ex_imm_extend <= id_imm_extend;
		ma_imm_extend <= ex_imm_extend;
		ex_store_data <= id_store_data;
		ma_store_data <= ex_store_data;
		ex_write_addr <= id_write_addr;
		ma_write_addr <= ex_write_addr;
		wb_write_addr <= ma_write_addr;
		ma_alu_result <= ex_alu_result;
		wb_write_data <= ma_write_data;
	end

	// The memory stage never carries a load and a store at once
	a_dm_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		!(ma_do_dm_read && ma_do_dm_write));

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int ADDR_W = 16
) (
	input  wire                         clock,
	input  wire                         rst_n,
	mem_bus_if.arbiter                  fetch_bus,
	mem_bus_if.arbiter                  data_bus,
	output logic                        mem_req,
	output logic                        mem_we,
	output logic [ADDR_W-1:0]           mem_addr,
	output logic [cpu_pkg::DATA_W-1:0] mem_wdata,
	input  wire  [cpu_pkg::DATA_W-1:0] mem_rdata
);

	// Data accesses always win and fetch only gets an idle bus
	assign data_bus.gnt  = data_bus.req;
	assign fetch_bus.gnt = fetch_bus.req && !data_bus.req;

	assign mem_req   = data_bus.gnt || fetch_bus.gnt;
	assign mem_we    = data_bus.gnt ? data_bus.we : (fetch_bus.gnt && fetch_bus.we);
	assign mem_addr  = data_bus.gnt ? data_bus.addr : fetch_bus.addr;
	assign mem_wdata = data_bus.gnt ? data_bus.wdata : fetch_bus.wdata;

	// The memory answers in the same cycle so both sides see the same read bus
	assign fetch_bus.rdata = mem_rdata;
	assign data_bus.rdata  = mem_rdata;

	// A fetch that loses the bus asks for the same word in the next cycle
	a_fetch_retry: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_bus.req && !fetch_bus.gnt |=> fetch_bus.req && $stable(fetch_bus.addr));

	// The fetch side only ever reads
	a_fetch_read_only: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_bus.req |-> !fetch_bus.we);

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int ADDR_W = 16
) (
	input  wire                         clock,
	input  wire                         rst_n,
	output logic                        mem_req,
	output logic                        mem_we,
	output logic [ADDR_W-1:0]           mem_addr,
	output logic [cpu_pkg::DATA_W-1:0] mem_wdata,
	input  wire  [cpu_pkg::DATA_W-1:0] mem_rdata,
	output logic                        alu_overflow
);
	import cpu_pkg::*;

	mem_bus_if #(.ADDR_W(ADDR_W)) fetch_bus ();
	mem_bus_if #(.ADDR_W(ADDR_W)) data_bus ();

	logic [DATA_W-1:0]     if_instruction;
	logic [DATA_W-1:0]     id_instruction;

	opcode_e               id_opcode;
	alu_op_e               id_alu_op;
	logic [REG_ADDR_W-1:0] id_rt;
	logic [REG_ADDR_W-1:0] id_ra;
	logic [REG_ADDR_W-1:0] id_rb;
	logic [REG_ADDR_W-1:0] id_rb_addr;
	logic [DATA_W-1:0]     id_imm_extend;
	logic                  id_use_imm;
	wb_sel_e               id_wb_sel;
	logic                  id_do_dm_read;
	logic                  id_do_dm_write;
	logic                  id_do_reg_write;
	logic [DATA_W-1:0]     id_ra_data;
	logic [DATA_W-1:0]     id_rb_data;
	logic [DATA_W-1:0]     id_src2;

	logic [DATA_W-1:0]     ex_ra_data;
	logic [DATA_W-1:0]     ex_src2;
	alu_op_e               ex_alu_op;
	logic [DATA_W-1:0]     ex_alu_result;
	logic                  ex_overflow;

	wb_sel_e               ma_wb_sel;
	logic [DATA_W-1:0]     ma_imm_extend;
	logic [DATA_W-1:0]     ma_store_data;
	logic                  ma_do_dm_read;
	logic                  ma_do_dm_write;
	logic [DATA_W-1:0]     ma_alu_result;
	logic [DATA_W-1:0]     ma_write_data;

	logic [REG_ADDR_W-1:0] wb_write_addr;
	logic                  wb_do_reg_write;
	logic [DATA_W-1:0]     wb_write_data;

	fetch_unit #(.ADDR_W(ADDR_W)) i_fetch_unit (
		.clock       (clock),
		.rst_n       (rst_n),
		.fetch_bus   (fetch_bus.manager),
		.instruction (if_instruction)
	);

	decoder i_decoder (
		.instruction  (id_instruction),
		.opcode       (id_opcode),
		.alu_op       (id_alu_op),
		.rt           (id_rt),
		.ra           (id_ra),
		.rb           (id_rb),
		.imm_extend   (id_imm_extend),
		.use_imm      (id_use_imm),
		.wb_sel       (id_wb_sel),
		.do_dm_read   (id_do_dm_read),
		.do_dm_write  (id_do_dm_write),
		.do_reg_write (id_do_reg_write)
	);

	// A store reads its data register through the second port
	assign id_rb_addr = (id_opcode == OP_SWI) ? id_rt : id_rb;

	regfile i_regfile (
		.clock      (clock),
		.rst_n      (rst_n),
		.ra_addr    (id_ra),
		.rb_addr    (id_rb_addr),
		.write_en   (wb_do_reg_write),
		.write_addr (wb_write_addr),
		.write_data (wb_write_data),
		.ra_data    (id_ra_data),
		.rb_data    (id_rb_data)
	);

	assign id_src2 = id_use_imm ? id_imm_extend : id_rb_data;

	regwalls i_regwalls (
		.clock           (clock),
		.rst_n           (rst_n),
		.if_instruction  (if_instruction),
		.id_instruction  (id_instruction),
		.id_ra_data      (id_ra_data),
		.id_src2         (id_src2),
		.id_alu_op       (id_alu_op),
		.ex_ra_data      (ex_ra_data),
		.ex_src2         (ex_src2),
		.ex_alu_op       (ex_alu_op),
		.id_wb_sel       (id_wb_sel),
		.id_imm_extend   (id_imm_extend),
		.id_store_data   (id_rb_data),
		.ma_wb_sel       (ma_wb_sel),
		.ma_imm_extend   (ma_imm_extend),
		.ma_store_data   (ma_store_data),
		.id_write_addr   (id_rt),
		.id_do_dm_read   (id_do_dm_read),
		.id_do_dm_write  (id_do_dm_write),
		.id_do_reg_write (id_do_reg_write),
		.wb_write_addr   (wb_write_addr),
		.ma_do_dm_read   (ma_do_dm_read),
		.ma_do_dm_write  (ma_do_dm_write),
		.wb_do_reg_write (wb_do_reg_write),
		.ex_alu_result   (ex_alu_result),
		.ex_overflow     (ex_overflow),
		.ma_alu_result   (ma_alu_result),
		.ma_overflow     (alu_overflow),
		.ma_write_data   (ma_write_data),
		.wb_write_data   (wb_write_data)
	);

	alu i_alu (
		.alu_op   (ex_alu_op),
		.src1     (ex_ra_data),
		.src2     (ex_src2),
		.result   (ex_alu_result),
		.overflow (ex_overflow)
	);

	// Memory stage requester, the ALU result is the byte address
	assign data_bus.req   = ma_do_dm_read || ma_do_dm_write;
	assign data_bus.we    = ma_do_dm_write;
	assign data_bus.addr  = ma_alu_result[ADDR_W-1:0];
	assign data_bus.wdata = ma_store_data;

	assign ma_write_data = (ma_wb_sel == WB_MEM) ? data_bus.rdata :
		(ma_wb_sel == WB_IMM) ? ma_imm_extend : ma_alu_result;

	mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
		.clock     (clock),
		.rst_n     (rst_n),
		.fetch_bus (fetch_bus.arbiter),
		.data_bus  (data_bus.arbiter),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
	import cpu_pkg::*;

	localparam int ADDR_W        = 16;
	localparam int MEM_AW        = ADDR_W - 2;
	localparam int MEM_WORDS     = 2**MEM_AW;
	localparam int RESET_CYCLES  = 16;
	localparam int STORE_TIMEOUT = 200;
	localparam int RANDOM_ROWS   = 8;

	// Byte addresses as imm14 fields, and the matching word indices
	localparam logic [13:0]       OPA_ADDR    = 14'h100;
	localparam logic [13:0]       OPB_ADDR    = 14'h104;
	localparam logic [13:0]       RESULT_ADDR = 14'h200;
	localparam logic [MEM_AW-1:0] OPA_WORD    = 14'd64;
	localparam logic [MEM_AW-1:0] OPB_WORD    = 14'd65;

	localparam logic [2:0] K_ALU  = 3'd0;
	localparam logic [2:0] K_ADDI = 3'd1;
	localparam logic [2:0] K_MOVI = 3'd2;
	localparam logic [2:0] K_COPY = 3'd3;
	localparam logic [2:0] K_ZERO = 3'd4;

	typedef struct packed {
		logic [2:0]  kind;
		logic [4:0]  sub;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expect_word;
		logic        expect_ovf;
	} row_t;

	logic              clock;
	logic              rst_n;
	logic              mem_req;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [31:0]       mem_wdata;
	logic [31:0]       mem_rdata;
	logic              alu_overflow;

	logic [31:0] mem [MEM_WORDS];
	row_t        rows[$];

	int              store_count;
	logic [15:0]     store_addr;
	logic [31:0]     store_data;
	logic            ovf_seen;
	int              bus_in_reset = 0;
	logic            first_req_seen;
	logic [15:0]     first_req_addr;
	int              checks = 0;
	int              errors = 0;
	int              timeouts = 0;

	cpu_top #(.ADDR_W(ADDR_W)) i_cpu_top (
		.clock        (clock),
		.rst_n        (rst_n),
		.mem_req      (mem_req),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.alu_overflow (alu_overflow)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Zero-wait memory that answers reads in the same cycle
	assign mem_rdata = mem[mem_addr[ADDR_W-1:2]];

	// Stores and the overflow flag are recorded on the rising edge
	always @(posedge clock) begin
		if (!rst_n) begin
			store_count <= 0;
			ovf_seen    <= 1'b0;
			if (mem_req || mem_we)
				bus_in_reset <= bus_in_reset + 1;
		end else begin
			if (mem_req && mem_we) begin
				store_count <= store_count + 1;
				store_addr  <= mem_addr;
				store_data  <= mem_wdata;
			end
			if (alu_overflow)
				ovf_seen <= 1'b1;
		end
	end

	// Records the address of the first request after reset
	always @(negedge clock) begin
		if (!rst_n) begin
			first_req_seen <= 1'b0;
		end else if (mem_req && !first_req_seen) begin
			first_req_seen <= 1'b1;
			first_req_addr <= mem_addr;
		end
	end

	function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] sub);
		return {1'b0, op, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] imm);
		return {1'b0, op, rt, ra, 1'b0, imm};
	endfunction

	// MOVI shares its top immediate nibble with the low bits of rt
	function automatic logic [31:0] enc_movi(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, OP_MOVI, rt, imm};
	endfunction

	function automatic logic [31:0] alu_model(input logic [4:0] sub, input logic [31:0] a,
			input logic [31:0] b);
		case (sub)
			SUB_ADD: return a + b;
			SUB_SUB: return a - b;
			SUB_AND: return a & b;
			SUB_OR:  return a | b;
			default: return a ^ b;
		endcase
	endfunction

	function automatic logic ovf_model(input logic [4:0] sub, input logic [31:0] a,
			input logic [31:0] b);
		longint sa;
		longint sb;
		longint r;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		if (sub == SUB_ADD)
			r = sa + sb;
		else if (sub == SUB_SUB)
			r = sa - sb;
		else
			return 1'b0;
		return (r > 64'sd2147483647) || (r < -64'sd2147483648);
	endfunction

	function automatic row_t make_row(input logic [2:0] kind, input logic [4:0] sub,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_word,
			input logic exp_ovf);
		return '{kind, sub, a, b, exp_word, exp_ovf};
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Operands come in by LWI and three NOPs guard each dependency
	task automatic load_program(input row_t r);
		logic [31:0] op_word;
		logic [4:0]  src;
		src = 5'd3;
		case (r.kind)
			K_ALU:   op_word = enc_r(OP_ALU, 5'd3, 5'd1, 5'd2, r.sub);
			K_ADDI:  op_word = enc_i(OP_ADDI, 5'd3, 5'd1, r.b[13:0]);
			K_COPY:  op_word = enc_i(OP_LWI, 5'd3, 5'd0, OPB_ADDR);
			K_MOVI: begin
				op_word = enc_movi(5'd11, r.b[19:0]);
				src     = 5'd11;
			end
			default: begin
				op_word = enc_r(OP_ALU, 5'd0, 5'd1, 5'd2, SUB_ADD);
				src     = 5'd0;
			end
		endcase
		mem[14'd0] = enc_i(OP_LWI, 5'd1, 5'd0, OPA_ADDR);
		mem[14'd1] = enc_i(OP_LWI, 5'd2, 5'd0, OPB_ADDR);
		mem[14'd5] = op_word;
		mem[14'd9] = enc_i(OP_SWI, src, 5'd0, RESULT_ADDR);
		mem[OPA_WORD] = r.a;
		mem[OPB_WORD] = r.b;
	endtask

	task automatic wait_for_store(output logic seen);
		int cycles;
		cycles = 0;
		while (store_count == 0 && cycles < STORE_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		seen = (store_count != 0);
	endtask

	task automatic run_row(input row_t r, input int n);
		logic seen;
		@(posedge clock);
		rst_n <= 1'b0;
		load_program(r);
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		wait_for_store(seen);
		if (!seen) begin
			timeouts++;
			$display("Row %0d: no store was seen within %0d cycles", n, STORE_TIMEOUT);
		end else begin
			check({16'b0, store_addr}, {18'b0, RESULT_ADDR}, $sformatf("row %0d address", n));
			check(store_data, r.expect_word, $sformatf("row %0d stored word", n));
			check({31'b0, ovf_seen}, {31'b0, r.expect_ovf}, $sformatf("row %0d overflow", n));
			check({16'b0, first_req_addr}, 32'd0, $sformatf("row %0d first address", n));
		end
		check(bus_in_reset, 32'd0, $sformatf("row %0d bus activity during reset", n));
	endtask

	initial begin
		int          seed;
		int          i;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  sub;
		rst_n = 1'b0;
		seed  = 30;
		for (i = 0; i < MEM_WORDS; i++)
			mem[i[MEM_AW-1:0]] = NOP_WORD;

		rows.push_back(make_row(K_ALU, SUB_ADD, 32'd5, 32'd7, 32'd12, 1'b0));
		rows.push_back(make_row(K_ALU, SUB_SUB, 32'd3, 32'd10, 32'hFFFF_FFF9, 1'b0));
		rows.push_back(make_row(K_ALU, SUB_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b0));
		rows.push_back(make_row(K_ALU, SUB_OR, 32'hA000_0005, 32'h0000_0F00, 32'hA000_0F05, 1'b0));
		rows.push_back(make_row(K_ALU, SUB_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F, 1'b0));
		rows.push_back(make_row(K_ALU, SUB_ADD, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000, 1'b1));
		rows.push_back(make_row(K_ALU, SUB_SUB, 32'h8000_0000, 32'd1, 32'h7FFF_FFFF, 1'b1));
		rows.push_back(make_row(K_ADDI, SUB_ADD, 32'd100, 32'h0000_3FFD, 32'd97, 1'b0));
		rows.push_back(make_row(K_ADDI, SUB_ADD, 32'h10, 32'h0000_2000, 32'hFFFF_E010, 1'b0));
		// rt is r11 so the 24-bit immediate is negative
		rows.push_back(make_row(K_MOVI, SUB_ADD, 32'd0, 32'h0001_2345, 32'hFFB1_2345, 1'b0));
		rows.push_back(make_row(K_COPY, SUB_ADD, 32'd1, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0));
		rows.push_back(make_row(K_ZERO, SUB_ADD, 32'd5, 32'd6, 32'd0, 1'b0));

		for (i = 0; i < RANDOM_ROWS; i++) begin
			a = $random(seed);
			b = $random(seed);
			case ($unsigned($random(seed)) % 5)
				0:       sub = SUB_ADD;
				1:       sub = SUB_SUB;
				2:       sub = SUB_AND;
				3:       sub = SUB_OR;
				default: sub = SUB_XOR;
			endcase
			rows.push_back(make_row(K_ALU, sub, a, b, alu_model(sub, a, b),
				ovf_model(sub, a, b)));
		end

		for (i = 0; i < rows.size(); i++)
			run_row(rows[i], i);

		$display("Rows: %0d, checks: %0d, errors: %0d, timeouts: %0d",
			rows.size(), checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/regwalls.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
testbench/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_cpu_top -f sim.f \
	&& ./obj_dir/Vtb_cpu_top | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
